// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := mem_subsys_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# passes only when the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/mem_arbiter.sv
module mem_arbiter (
	input  logic                          clk,
	input  logic                          rst,
	// fetch port reads only
	input  logic                          if_req,
	input  logic [mem_pkg::ADDR_W-1:0]    if_addr,
	output logic                          if_done,
	output logic [mem_pkg::DATA_W-1:0]    if_rdata,
	output logic                          if_err,
	// load/store port
	input  logic                          ls_req,
	input  logic                          ls_we,
	input  logic [mem_pkg::ADDR_W-1:0]    ls_addr,
	input  logic [mem_pkg::DATA_W-1:0]    ls_wdata,
	input  logic [mem_pkg::STRB_W-1:0]    ls_wstrb,
	output logic                          ls_done,
	output logic [mem_pkg::DATA_W-1:0]    ls_rdata,
	output logic                          ls_err,
	// read address
	output logic                          arvalid,
	output logic [mem_pkg::ADDR_W-1:0]    araddr,
	input  logic                          arready,
	// read data
	input  logic                          rvalid,
	input  logic [mem_pkg::DATA_W-1:0]    rdata,
	input  logic [mem_pkg::RESP_W-1:0]    rresp,
	output logic                          rready,
	// write address
	output logic                          awvalid,
	output logic [mem_pkg::ADDR_W-1:0]    awaddr,
	input  logic                          awready,
	// write data
	output logic                          wvalid,
	output logic [mem_pkg::DATA_W-1:0]    wdata,
	output logic [mem_pkg::STRB_W-1:0]    wstrb,
	input  logic                          wready,
	// write response
	input  logic                          bvalid,
	input  logic [mem_pkg::RESP_W-1:0]    bresp,
	output logic                          bready
);

	logic [mem_pkg::ARB_ST_W-1:0] st;
	// 1 when the load/store port won the last grant
	logic last_ls;
	logic op_we;
	logic pick_ls;
	logic addr_done;
	logic rsp_seen;

	// latched operands of the granted port
	logic [mem_pkg::ADDR_W-1:0] op_addr;
	logic [mem_pkg::DATA_W-1:0] op_wdata;
	logic [mem_pkg::STRB_W-1:0] op_wstrb;

	// captured response
	logic [mem_pkg::DATA_W-1:0] rsp_data;
	logic rsp_err;

	// a tie goes to the port that lost last time
	assign pick_ls = ls_req && (!if_req || !last_ls);

	// address phase ends on the AR edge or the joint AW/W edge
	assign addr_done = op_we ? (awvalid && awready && wvalid && wready)
	                         : (arvalid && arready);
	assign rsp_seen = op_we ? (bvalid && bready) : (rvalid && rready);

	always_ff @(posedge clk) begin
		if (rst) begin
			st <= mem_pkg::ARB_IDLE;
			last_ls <= 1'b0;
			op_we <= 1'b0;
		end else begin
			case (st)
				mem_pkg::ARB_IDLE: begin
					if (if_req || ls_req) begin
						last_ls <= pick_ls;
						// fetch never writes
						op_we <= pick_ls && ls_we;
						st <= mem_pkg::ARB_ADDR;
					end
				end
				mem_pkg::ARB_ADDR: begin
					if (addr_done) begin
						st <= mem_pkg::ARB_RESP;
					end
				end
				mem_pkg::ARB_RESP: begin
					if (rsp_seen) begin
						st <= mem_pkg::ARB_DONE;
					end
				end
				default: begin
					// done pulse lasts this one cycle
					st <= mem_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	// operands follow the winner while idle and freeze once granted
	always_ff @(posedge clk) begin
		if (st == mem_pkg::ARB_IDLE) begin
			op_addr <= pick_ls ? ls_addr : if_addr;
			op_wdata <= ls_wdata;
			op_wstrb <= ls_wstrb;
		end
	end

	// response taken on its handshake edge
	always_ff @(posedge clk) begin
		if (st == mem_pkg::ARB_RESP && rsp_seen) begin
			rsp_err <= (op_we ? bresp : rresp) != mem_pkg::RESP_OKAY;
			rsp_data <= op_we ? '0 : rdata;
		end
	end

	// channel master side
	assign arvalid = st == mem_pkg::ARB_ADDR && !op_we;
	assign araddr = op_addr;
	// AW and W always raised together
	assign awvalid = st == mem_pkg::ARB_ADDR && op_we;
	assign wvalid = st == mem_pkg::ARB_ADDR && op_we;
	assign awaddr = op_addr;
	assign wdata = op_wdata;
	assign wstrb = op_wstrb;
	assign rready = st == mem_pkg::ARB_RESP && !op_we;
	assign bready = st == mem_pkg::ARB_RESP && op_we;

	// data and err valid together with done
	assign if_done = st == mem_pkg::ARB_DONE && !last_ls;
	assign ls_done = st == mem_pkg::ARB_DONE && last_ls;
	assign if_rdata = rsp_data;
	assign ls_rdata = rsp_data;
	assign if_err = rsp_err;
	assign ls_err = rsp_err;

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

	// byte address and data path widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;
	localparam int BYTE_W = 8;

	// 1024 words of 64 bits, 8 KiB in all
	localparam int MEM_WORDS = 1024;
	localparam int IDX_W = $clog2(MEM_WORDS);
	// word index starts above the byte offset
	localparam int IDX_LSB = 3;

	// response codes on rresp and bresp
	localparam int RESP_W = 2;
	localparam logic [RESP_W-1:0] RESP_OKAY = 2'd0;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

	// slave channel machines, one bit each
	localparam logic SLV_IDLE = 1'b0;
	localparam logic SLV_RESP = 1'b1;

	// arbiter sequence
	localparam int ARB_ST_W = 2;
	localparam logic [ARB_ST_W-1:0] ARB_IDLE = 2'd0;
	// address phase, AR or AW with W
	localparam logic [ARB_ST_W-1:0] ARB_ADDR = 2'd1;
	localparam logic [ARB_ST_W-1:0] ARB_RESP = 2'd2;
	localparam logic [ARB_ST_W-1:0] ARB_DONE = 2'd3;

endpackage

// File: hw/mem_subsys_top.sv
module mem_subsys_top (
	input  logic                          clk,
	input  logic                          rst,
	// fetch port
	input  logic                          if_req,
	input  logic [mem_pkg::ADDR_W-1:0]    if_addr,
	output logic                          if_done,
	output logic [mem_pkg::DATA_W-1:0]    if_rdata,
	output logic                          if_err,
	// load/store port
	input  logic                          ls_req,
	input  logic                          ls_we,
	input  logic [mem_pkg::ADDR_W-1:0]    ls_addr,
	input  logic [mem_pkg::DATA_W-1:0]    ls_wdata,
	input  logic [mem_pkg::STRB_W-1:0]    ls_wstrb,
	output logic                          ls_done,
	output logic [mem_pkg::DATA_W-1:0]    ls_rdata,
	output logic                          ls_err
);

	// arbiter to slave channels
	logic                          arvalid;
	logic [mem_pkg::ADDR_W-1:0]    araddr;
	logic                          arready;
	logic                          rvalid;
	logic [mem_pkg::DATA_W-1:0]    rdata;
	logic [mem_pkg::RESP_W-1:0]    rresp;
	logic                          rready;
	logic                          awvalid;
	logic [mem_pkg::ADDR_W-1:0]    awaddr;
	logic                          awready;
	logic                          wvalid;
	logic [mem_pkg::DATA_W-1:0]    wdata;
	logic [mem_pkg::STRB_W-1:0]    wstrb;
	logic                          wready;
	logic                          bvalid;
	logic [mem_pkg::RESP_W-1:0]    bresp;
	logic                          bready;

	// slave to store
	logic                          ren;
	logic [mem_pkg::IDX_W-1:0]     ridx;
	logic [mem_pkg::DATA_W-1:0]    rdat;
	logic                          wen;
	logic [mem_pkg::IDX_W-1:0]     widx;
	logic [mem_pkg::STRB_W-1:0]    wbe;
	logic [mem_pkg::DATA_W-1:0]    wdat;

	mem_arbiter u_arbiter (
		.clk(clk), .rst(rst),
		.if_req(if_req), .if_addr(if_addr), .if_done(if_done),
		.if_rdata(if_rdata), .if_err(if_err),
		.ls_req(ls_req), .ls_we(ls_we), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
		.ls_wstrb(ls_wstrb), .ls_done(ls_done), .ls_rdata(ls_rdata), .ls_err(ls_err),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready)
	);

	sram_slave u_slave (
		.clk(clk), .rst(rst),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.ren(ren), .ridx(ridx), .rdat(rdat),
		.wen(wen), .widx(widx), .wbe(wbe), .wdat(wdat)
	);

	sram_store u_store (
		.clk(clk),
		.ren(ren), .ridx(ridx), .rdat(rdat),
		.wen(wen), .widx(widx), .wbe(wbe), .wdat(wdat)
	);

endmodule

// File: hw/sram_slave.sv
module sram_slave (
	input  logic                          clk,
	input  logic                          rst,
	// read address
	input  logic                          arvalid,
	input  logic [mem_pkg::ADDR_W-1:0]    araddr,
	output logic                          arready,
	// read data
	output logic                          rvalid,
	output logic [mem_pkg::DATA_W-1:0]    rdata,
	output logic [mem_pkg::RESP_W-1:0]    rresp,
	input  logic                          rready,
	// write address
	input  logic                          awvalid,
	input  logic [mem_pkg::ADDR_W-1:0]    awaddr,
	output logic                          awready,
	// write data
	input  logic                          wvalid,
	input  logic [mem_pkg::DATA_W-1:0]    wdata,
	input  logic [mem_pkg::STRB_W-1:0]    wstrb,
	output logic                          wready,
	// write response
	output logic                          bvalid,
	output logic [mem_pkg::RESP_W-1:0]    bresp,
	input  logic                          bready,
	// store side
	output logic                          ren,
	output logic [mem_pkg::IDX_W-1:0]     ridx,
	input  logic [mem_pkg::DATA_W-1:0]    rdat,
	output logic                          wen,
	output logic [mem_pkg::IDX_W-1:0]     widx,
	output logic [mem_pkg::STRB_W-1:0]    wbe,
	output logic [mem_pkg::DATA_W-1:0]    wdat
);

	logic rd_st;
	logic wr_st;
	logic rd_ok;
	logic wr_ok;
	logic ar_fire;
	logic aw_fire;

	// in range when nothing is set above the word index
	assign rd_ok = araddr[mem_pkg::ADDR_W-1:mem_pkg::IDX_LSB+mem_pkg::IDX_W] == '0;
	assign wr_ok = awaddr[mem_pkg::ADDR_W-1:mem_pkg::IDX_LSB+mem_pkg::IDX_W] == '0;

	// read channel
	// accept only in idle, one read at a time
	assign arready = rd_st == mem_pkg::SLV_IDLE;
	assign ar_fire = arvalid && arready;

	// store read starts on the AR edge, data lands with rvalid
	assign ren = ar_fire && rd_ok;
	assign ridx = araddr[mem_pkg::IDX_LSB+mem_pkg::IDX_W-1:mem_pkg::IDX_LSB];

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_st <= mem_pkg::SLV_IDLE;
		end else begin
			case (rd_st)
				mem_pkg::SLV_IDLE: begin
					if (ar_fire) begin
						rd_st <= mem_pkg::SLV_RESP;
					end
				end
				default: begin
					// hold the beat until the master takes it
					if (rready) begin
						rd_st <= mem_pkg::SLV_IDLE;
					end
				end
			endcase
		end
	end

	// response code kept for the whole beat
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rresp <= rd_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end
	end

	assign rvalid = rd_st == mem_pkg::SLV_RESP;
	// zero data on error
	assign rdata = (rresp == mem_pkg::RESP_OKAY) ? rdat : '0;

	// write channel
	// address and data taken on the same edge
	assign awready = wr_st == mem_pkg::SLV_IDLE;
	assign wready = wr_st == mem_pkg::SLV_IDLE;
	assign aw_fire = awvalid && awready && wvalid && wready;

	// array written on the accept edge, bad address dropped
	assign wen = aw_fire && wr_ok;
	assign widx = awaddr[mem_pkg::IDX_LSB+mem_pkg::IDX_W-1:mem_pkg::IDX_LSB];
	assign wbe = wstrb;
	assign wdat = wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_st <= mem_pkg::SLV_IDLE;
		end else begin
			case (wr_st)
				mem_pkg::SLV_IDLE: begin
					if (aw_fire) begin
						wr_st <= mem_pkg::SLV_RESP;
					end
				end
				default: begin
					if (bready) begin
						wr_st <= mem_pkg::SLV_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			bresp <= wr_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end
	end

	assign bvalid = wr_st == mem_pkg::SLV_RESP;

endmodule

// File: hw/sram_store.sv
module sram_store (
	input  logic                          clk,
	// read port
	input  logic                          ren,
	input  logic [mem_pkg::IDX_W-1:0]     ridx,
	output logic [mem_pkg::DATA_W-1:0]    rdat,
	// write port
	input  logic                          wen,
	input  logic [mem_pkg::IDX_W-1:0]     widx,
	input  logic [mem_pkg::STRB_W-1:0]    wbe,
	input  logic [mem_pkg::DATA_W-1:0]    wdat
);

	// plain word array, a RAM macro can take its place later
	logic [mem_pkg::DATA_W-1:0] mem [mem_pkg::MEM_WORDS];

	// byte lane writes
	always_ff @(posedge clk) begin
		if (wen) begin
			for (int b = 0; b < mem_pkg::STRB_W; b++) begin
				// only lanes with their strobe set
				if (wbe[b]) begin
					mem[widx][b*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] <=
						wdat[b*mem_pkg::BYTE_W +: mem_pkg::BYTE_W];
				end
			end
		end
	end

	// registered read, data one cycle after ren
	// old data when read and write hit the same word
	always_ff @(posedge clk) begin
		if (ren) begin
			rdat <= mem[ridx];
		end
	end

	// rdat keeps its value until the next ren
	// the slave relies on that while rvalid waits

endmodule

// File: project.f
hw/mem_pkg.sv
hw/sram_store.sv
hw/sram_slave.sv
hw/mem_arbiter.sv
hw/mem_subsys_top.sv
verification/mem_subsys_asserts.sv
verification/mem_subsys_tb.sv

// File: verification/mem_subsys_asserts.sv
module mem_subsys_asserts (
	input logic                          clk,
	input logic                          rst,
	input logic                          rvalid,
	input logic                          rready,
	input logic [mem_pkg::DATA_W-1:0]    rdata,
	input logic [mem_pkg::RESP_W-1:0]    rresp,
	input logic                          bvalid,
	input logic                          bready
);
	timeunit 1ns;
	timeprecision 1ps;

	// failures seen so far
	int fail_count;

	// read beat held until the master takes it
	rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else begin
			fail_count++;
			$error("rvalid dropped before rready");
		end

	// payload frozen while waiting
	rdata_stable: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> $stable(rdata) && $stable(rresp))
		else begin
			fail_count++;
			$error("rdata or rresp changed while rvalid waited");
		end

	// write response held the same way
	bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else begin
			fail_count++;
			$error("bvalid dropped before bready");
		end

	// both response channels quiet right after reset
	reset_quiet: assert property (@(posedge clk) rst |=> !rvalid && !bvalid)
		else begin
			fail_count++;
			$error("rvalid or bvalid high in the cycle after reset");
		end

endmodule

bind sram_slave mem_subsys_asserts u_asserts (
	.clk(clk), .rst(rst),
	.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
	.bvalid(bvalid), .bready(bready)
);

// File: verification/mem_subsys_tb.sv
module mem_subsys_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'h2e82a0d4;
	// cycles a port may wait for its done
	localparam int DONE_TIMEOUT = 64;
	localparam int MEM_BYTES = mem_pkg::MEM_WORDS * 8;
	localparam int DIRECTED_ROUNDS = 64;
	// 2200 transactions in the random mix
	localparam int MIX_FETCHES = 1000;
	localparam int MIX_LS = 1200;
	// both ports held busy
	localparam int HOLD_EACH = 100;

	logic        clk;
	logic        rst;
	logic        if_req;
	logic [31:0] if_addr;
	logic        if_done;
	logic [63:0] if_rdata;
	logic        if_err;
	logic        ls_req;
	logic        ls_we;
	logic [31:0] ls_addr;
	logic [63:0] ls_wdata;
	logic [7:0]  ls_wstrb;
	logic        ls_done;
	logic [63:0] ls_rdata;
	logic        ls_err;

	// reference memory with one entry per byte
	logic [7:0] model [MEM_BYTES];
	// word each port is busy with or -1
	int if_cur;
	int ls_cur;
	// last port served as 0 fetch or 1 load/store or -1
	int last_port;
	bit check_turns;

	mem_subsys_top UUT (.*);

	always #2 clk = ~clk;

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// low three bits ignored and index wrapping above the array
	function automatic int word_index(input logic [31:0] addr);
		return int'(addr >> 3) % mem_pkg::MEM_WORDS;
	endfunction

	function automatic logic [63:0] model_word(input int idx);
		logic [63:0] w;
		for (int b = 0; b < 8; b++) begin
			w[b*8 +: 8] = model[idx * 8 + b];
		end
		return w;
	endfunction

	task automatic model_write(input int idx, input logic [63:0] data, input logic [7:0] strb);
		for (int b = 0; b < 8; b++) begin
			// enabled lanes only
			if (strb[b]) begin
				model[idx * 8 + b] = data[b*8 +: 8];
			end
		end
	endtask

	// random address kept off the other port's word when in range
	function automatic logic [31:0] pick_addr(input int avoid, input bit bad);
		int idx;
		logic [31:0] addr;
		if (bad) begin
			// some bit at 13 or above set
			addr = $urandom | (32'h1 << $urandom_range(31, 13));
		end else begin
			do begin
				idx = $urandom_range(mem_pkg::MEM_WORDS - 1, 0);
			end while (idx == avoid);
			addr = 32'(idx * 8) | $urandom_range(7, 0);
		end
		return addr;
	endfunction

	task automatic fetch_read(input logic [31:0] addr);
		int waited;
		bit in_range;
		logic [63:0] exp;
		in_range = addr < MEM_BYTES;
		if_cur = word_index(addr);
		if_req = 1'b1;
		if_addr = addr;
		waited = 0;
		@(negedge clk);
		while (!if_done) begin
			assert (waited < DONE_TIMEOUT)
				else stop_with_error("fetch port hung, if_done never arrived");
			@(negedge clk);
			waited++;
		end
		// out of range reads come back as zero
		exp = in_range ? model_word(if_cur) : '0;
		assert (if_err == !in_range)
			else stop_with_error($sformatf("ERROR if_err: got %h expected %h addr %h",
				if_err, !in_range, addr));
		assert (if_rdata == exp)
			else stop_with_error($sformatf("ERROR if_rdata: got %h expected %h addr %h",
				if_rdata, exp, addr));
		if (check_turns) begin
			assert (last_port != 0)
				else stop_with_error("fetch port was served twice in a row under full load");
		end
		last_port = 0;
		if_cur = -1;
		if_req = 1'b0;
	endtask

	task automatic ls_access(input bit we, input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb);
		int waited;
		bit in_range;
		logic [63:0] exp;
		in_range = addr < MEM_BYTES;
		ls_cur = word_index(addr);
		ls_req = 1'b1;
		ls_we = we;
		ls_addr = addr;
		ls_wdata = data;
		ls_wstrb = strb;
		waited = 0;
		@(negedge clk);
		while (!ls_done) begin
			assert (waited < DONE_TIMEOUT)
				else stop_with_error("load/store port hung, ls_done never arrived");
			@(negedge clk);
			waited++;
		end
		assert (ls_err == !in_range)
			else stop_with_error($sformatf("ERROR ls_err: got %h expected %h addr %h",
				ls_err, !in_range, addr));
		if (we) begin
			// good writes land in the model at done
			if (in_range) begin
				model_write(ls_cur, data, strb);
			end
		end else begin
			exp = in_range ? model_word(ls_cur) : '0;
			assert (ls_rdata == exp)
				else stop_with_error($sformatf("ERROR ls_rdata: got %h expected %h addr %h",
					ls_rdata, exp, addr));
		end
		if (check_turns) begin
			assert (last_port != 1)
				else stop_with_error("load/store port was served twice in a row under full load");
		end
		last_port = 1;
		ls_cur = -1;
		ls_req = 1'b0;
	endtask

	// gap 0 keeps req high from one transaction to the next
	task automatic fetch_stream(input int count, input int max_gap);
		int gap;
		for (int n = 0; n < count; n++) begin
			fetch_read(pick_addr(ls_cur, $urandom_range(9, 0) == 0));
			gap = $urandom_range(max_gap, 0);
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic ls_stream(input int count, input int max_gap);
		int gap;
		bit we;
		logic [31:0] addr;
		for (int n = 0; n < count; n++) begin
			we = $urandom_range(1, 0) == 1;
			addr = pick_addr(if_cur, $urandom_range(9, 0) == 0);
			ls_access(we, addr, {$urandom, $urandom}, 8'($urandom));
			gap = $urandom_range(max_gap, 0);
			repeat (gap) @(negedge clk);
		end
	endtask

	// strobed write and read back then fetch reads and out of range cases
	task automatic run_directed(input int rounds);
		logic [31:0] addr;
		logic [31:0] bad;
		for (int n = 0; n < rounds; n++) begin
			addr = pick_addr(-1, 1'b0);
			ls_access(1'b1, addr, {$urandom, $urandom}, 8'($urandom));
			ls_access(1'b0, addr, '0, '0);
			fetch_read(addr);
			fetch_read(pick_addr(-1, 1'b0));
			bad = pick_addr(-1, 1'b1);
			ls_access(1'b1, bad, {$urandom, $urandom}, 8'hff);
			ls_access(1'b0, bad, '0, '0);
			fetch_read(bad);
			// aliased low word must not have changed
			fetch_read(32'(word_index(bad) * 8));
		end
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst = 1'b1;
		if_req = 1'b0;
		if_addr = '0;
		ls_req = 1'b0;
		ls_we = 1'b0;
		ls_addr = '0;
		ls_wdata = '0;
		ls_wstrb = '0;
		if_cur = -1;
		ls_cur = -1;
		last_port = -1;
		check_turns = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// quiet after reset
		for (int n = 0; n < 10; n++) begin
			@(negedge clk);
			assert (!if_done && !ls_done)
				else stop_with_error($sformatf("ERROR if_done/ls_done: got %h/%h expected 0/0",
					if_done, ls_done));
		end

		// fill every word with full strobes
		for (int idx = 0; idx < mem_pkg::MEM_WORDS; idx++) begin
			ls_access(1'b1, 32'(idx * 8), {$urandom, $urandom}, 8'hff);
		end

		run_directed(DIRECTED_ROUNDS);

		fork
			fetch_stream(MIX_FETCHES, 3);
			ls_stream(MIX_LS, 3);
		join
		repeat (2) @(negedge clk);

		// grants alternate while both ports keep requesting
		last_port = -1;
		check_turns = 1'b1;
		fork
			fetch_stream(HOLD_EACH, 0);
			ls_stream(HOLD_EACH, 0);
		join
		check_turns = 1'b0;

		if (UUT.u_slave.u_asserts.fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("slave channel protocol assertions failed %0d times",
				UUT.u_slave.u_asserts.fail_count);
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule
